// ==== pu_cfg.mem ====
// One layer per line: {kw[1:0], iw[9:0], pad[2:0], stride[2:0]} as 18-bit hex
203C9
30512
10303

// ==== weights.mem ====
// Line layer*4+pe holds four signed 8-bit weights, tap 0 in the low byte
030201FF
7F80057E
11F0E2D3
00000100
04FD0201
81C0407F
10203040
FFFFFFFF
000005FB
55AA0C88
7E7E0101
40C00302

// ==== pu_top.f ====
pu_pkg.sv
pu_controller.sv
vectorgen.sv
window_fifo.sv
pe_array.sv
pu_top.sv
pu_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the PU testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pu_tb -f pu_top.f \
	&& ./obj_dir/Vpu_tb > sim.log 2>&1 \
	|| { echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation PASSED"; exit 0; }

// ==== pu_tb.sv ====
`timescale 1ns/1ps

module pu_tb import pu_pkg::*; ();

	logic clk;
	logic reset;
	logic start;
	logic rd_ready;
	op_t rd_data;
	logic rd_valid;
	logic read_req;
	addr_t read_addr;
	logic out_valid;
	result_t out_data;
	logic done;

	op_t in_mem [1 << ADDR_WIDTH];
	layer_cfg_t cfg_rom [NUM_LAYERS];
	weight_vec_t weight_rom [NUM_LAYERS*NUM_PE];
	result_t exp_results [$];
	addr_t exp_addrs [$];
	int value_errors;
	int protocol_errors;
	int starts_issued;
	int done_count;
	int timeout_cycles;
	logic busy;
	logic prev_done;
	logic req_seen;
	addr_t req_addr;

	pu_top uut (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.rd_ready  (rd_ready),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.read_req  (read_req),
		.read_addr (read_addr),
		.out_valid (out_valid),
		.out_data  (out_data),
		.done      (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic op_t padded_sample(layer_cfg_t c, int p);
		if (p < int'(c.pad) || p > int'(c.pad) + int'(c.iw))
			return '0;
		return in_mem[p - int'(c.pad)];
	endfunction

	// Expected reads and results for one pass over all layers
	task automatic build_expected();
		int pw;
		int nwin;
		acc_t acc;
		result_t r;
		logic signed [OP_WIDTH-1:0] s;
		logic signed [WEIGHT_WIDTH-1:0] wt;
		for (int l = 0; l < NUM_LAYERS; l++)
		begin
			pw = int'(cfg_rom[l].iw) + 1 + 2 * int'(cfg_rom[l].pad);
			nwin = (pw - int'(cfg_rom[l].kw) - 1) / int'(cfg_rom[l].stride) + 1;
			for (int a = 0; a <= int'(cfg_rom[l].iw); a++)
				exp_addrs.push_back(addr_t'(a));
			for (int k = 0; k < nwin; k++)
			begin
				for (int j = 0; j < NUM_PE; j++)
				begin
					acc = '0;
					for (int t = 0; t <= int'(cfg_rom[l].kw); t++)
					begin
						s = padded_sample(cfg_rom[l], k * int'(cfg_rom[l].stride) + t);
						wt = weight_rom[l*NUM_PE + j][t*WEIGHT_WIDTH +: WEIGHT_WIDTH];
						acc = acc + s * wt;
					end
					r.sums[j] = acc;
				end
				r.last = (k == nwin - 1);
				exp_results.push_back(r);
			end
		end
	endtask

	task automatic check_read();
		addr_t e;
		assert (rd_ready) else
		begin
			protocol_errors++;
			$display("read_req issued while rd_ready was low at %0t", $time);
		end
		if (exp_addrs.size() == 0)
		begin
			protocol_errors++;
			$display("Unexpected read of address %0d at %0t", read_addr, $time);
		end
		else
		begin
			e = exp_addrs.pop_front();
			assert (read_addr == e) else
			begin
				value_errors++;
				$display("Error: %0t read_addr expected %0d actual %0d", $time, e, read_addr);
			end
		end
	endtask

	task automatic check_result();
		result_t e;
		if (exp_results.size() == 0)
		begin
			protocol_errors++;
			$display("Result beyond the expected sequence at %0t", $time);
		end
		else
		begin
			e = exp_results.pop_front();
			for (int j = 0; j < NUM_PE; j++)
				assert (out_data.sums[j] == e.sums[j]) else
				begin
					value_errors++;
					$display("Error: %0t out_data.sums[%0d] expected %0d actual %0d", $time, j,
						$signed(e.sums[j]), $signed(out_data.sums[j]));
				end
			assert (out_data.last == e.last) else
			begin
				value_errors++;
				$display("Error: %0t out_data.last expected %0b actual %0b", $time, e.last,
					out_data.last);
			end
		end
	endtask

	task automatic check_done();
		assert (!prev_done) else
		begin
			protocol_errors++;
			$display("done stayed high for more than one cycle at %0t", $time);
		end
		assert (exp_results.size() == 0 && exp_addrs.size() == 0) else
		begin
			protocol_errors++;
			$display("done came with %0d results and %0d reads still missing at %0t",
				exp_results.size(), exp_addrs.size(), $time);
		end
		if (busy && !prev_done)
			done_count++;
	endtask

	// Input memory answers each read_req one cycle later
	always @(negedge clk)
	begin
		req_seen <= read_req;
		req_addr <= read_addr;
	end

	always @(posedge clk)
	begin
		#1;
		rd_valid <= req_seen;
		rd_data <= req_seen ? in_mem[req_addr] : '0;
		rd_ready <= (($urandom % 32'd4) != 32'd0);
	end

	always @(negedge clk)
	begin
		if (!reset)
		begin
			busy = (starts_issued != done_count);
			assert (busy || (!read_req && !out_valid && !done)) else
			begin
				protocol_errors++;
				$display("PU active while idle at %0t (read_req %0b, out_valid %0b, done %0b)",
					$time, read_req, out_valid, done);
			end
			if (read_req)
				check_read();
			if (out_valid)
				check_result();
			if (done)
				check_done();
		end
		prev_done = done;
	end

	task automatic finish_run(input logic timed_out);
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0 && !timed_out)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	initial
	begin
		#1;
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout: the PU did not finish within %0d cycles", timeout_cycles);
		finish_run(1'b1);
	end

	initial
	begin
		int max_pw;
		void'($urandom(32'h64912d07));
		reset = 1'b1;
		start = 1'b0;
		rd_ready = 1'b0;
		rd_valid = 1'b0;
		rd_data = '0;
		req_seen = 1'b0;
		req_addr = '0;
		value_errors = 0;
		protocol_errors = 0;
		starts_issued = 0;
		done_count = 0;
		$readmemh("pu_cfg.mem", cfg_rom);
		$readmemh("weights.mem", weight_rom);
		foreach (in_mem[a])
			in_mem[a] = op_t'($urandom);
		max_pw = 0;
		foreach (cfg_rom[l])
			if (int'(cfg_rom[l].iw) + 1 + 2 * int'(cfg_rom[l].pad) > max_pw)
				max_pw = int'(cfg_rom[l].iw) + 1 + 2 * int'(cfg_rom[l].pad);
		timeout_cycles = 2 * NUM_LAYERS * (max_pw * 8 + 50);
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		repeat (10) @(posedge clk); // Idle window before the first start
		for (int run = 0; run < 2; run++)
		begin
			build_expected();
			@(posedge clk);
			#1 start = 1'b1;
			starts_issued++;
			@(posedge clk);
			#1 start = 1'b0;
			wait (done_count == starts_issued);
			repeat (10) @(posedge clk); // No output may follow done
		end
		finish_run(1'b0);
	end

endmodule

// ==== pu_top.sv ====
`timescale 1ns/1ps

module pu_top import pu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	input  logic    rd_ready,
	input  op_t     rd_data,
	input  logic    rd_valid,
	output logic    read_req,
	output addr_t   read_addr,
	output logic    out_valid,
	output result_t out_data,
	output logic    done
);

	layer_cfg_t cfg;
	logic [1:0] layer_id;
	logic layer_start;
	logic layer_done;
	logic push;
	window_t push_data;
	logic pop;
	window_t pop_data;
	logic empty;
	logic almost_full;

	pu_controller u_controller (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.layer_done  (layer_done),
		.cfg         (cfg),
		.layer_id    (layer_id),
		.layer_start (layer_start),
		.done        (done)
	);

	vectorgen vecgen (
		.clk         (clk),
		.reset       (reset),
		.layer_start (layer_start),
		.cfg         (cfg),
		.rd_ready    (rd_ready),
		.almost_full (almost_full),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.read_req    (read_req),
		.read_addr   (read_addr),
		.push        (push),
		.push_data   (push_data)
	);

	window_fifo u_fifo (
		.clk         (clk),
		.reset       (reset),
		.push        (push),
		.push_data   (push_data),
		.pop         (pop),
		.pop_data    (pop_data),
		.empty       (empty),
		.almost_full (almost_full)
	);

	pe_array u_pe_array (
		.clk         (clk),
		.reset       (reset),
		.layer_id    (layer_id),
		.empty       (empty),
		.pop         (pop),
		.win         (pop_data),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.layer_done  (layer_done)
	);

endmodule

// ==== pe_array.sv ====
`timescale 1ns/1ps

module pe_array import pu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] layer_id,
	input  logic       empty,
	output logic       pop,
	input  window_t    win,
	output logic       out_valid,
	output result_t    out_data,
	output logic       layer_done
);

	weight_vec_t weight_rom [NUM_LAYERS*NUM_PE];
	acc_t [NUM_PE-1:0] sums;

	initial
	begin
		$readmemh("weights.mem", weight_rom);
	end

	assign pop = !empty;

	// One signed dot product per PE, all taps in a single stage
	always_comb
	begin
		acc_t acc;
		weight_vec_t wv;
		logic signed [OP_WIDTH-1:0] sample;
		logic signed [WEIGHT_WIDTH-1:0] weight;
		for (int j = 0; j < NUM_PE; j++)
		begin
			wv = weight_rom[int'(layer_id) * NUM_PE + j];
			acc = '0;
			for (int i = 0; i < MAX_KW; i++)
			begin
				sample = $signed(win.taps[i]);
				weight = $signed(wv[i*WEIGHT_WIDTH +: WEIGHT_WIDTH]);
				acc = acc + sample * weight; // Taps above kw are zero
			end
			sums[j] = acc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			out_data.sums <= sums;
			out_data.last <= win.last;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			layer_done <= 1'b0;
		end
		else
		begin
			out_valid <= pop;
			layer_done <= out_valid && out_data.last;
		end
	end

endmodule

// ==== window_fifo.sv ====
`timescale 1ns/1ps

module window_fifo import pu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    push,
	input  window_t push_data,
	input  logic    pop,
	output window_t pop_data,
	output logic    empty,
	output logic    almost_full
);

	window_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
	logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
	logic [FIFO_CNT_WIDTH-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && (count != FIFO_CNT_WIDTH'(FIFO_DEPTH));
	assign do_pop = pop && !empty;

	assign empty = (count == '0);
	assign almost_full = (count > FIFO_CNT_WIDTH'(FIFO_DEPTH - 2)); // Room for the read in flight
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two so pointers wrap
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + FIFO_CNT_WIDTH'(do_push) - FIFO_CNT_WIDTH'(do_pop);
		end
	end

endmodule

// ==== vectorgen.sv ====
`timescale 1ns/1ps

module vectorgen import pu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       layer_start,
	input  layer_cfg_t cfg,
	input  logic       rd_ready,
	input  logic       almost_full,
	input  op_t        rd_data,
	input  logic       rd_valid,
	output logic       read_req,
	output addr_t      read_addr,
	output logic       push,
	output window_t    push_data
);

	logic active;
	logic waiting; // A read is in flight
	logic tail; // Final window formed, remaining samples are only drained
	logic [1:0] skip; // Positions left until the next window end
	logic [POS_WIDTH-1:0] pos;
	logic [POS_WIDTH-1:0] last_real;
	logic [POS_WIDTH-1:0] last_pos;
	logic [POS_WIDTH-1:0] rem;
	logic is_zero;
	logic go;
	logic enter;
	logic win_end;
	logic last_win;
	logic final_pos;
	logic push_last;
	op_t sample;
	op_t [MAX_KW-1:0] taps;
	op_t [MAX_KW-1:0] shifted;
	op_t [MAX_KW-1:0] next_taps;

	assign last_real = POS_WIDTH'(cfg.pad) + POS_WIDTH'(cfg.iw);
	assign last_pos = last_real + POS_WIDTH'(cfg.pad);
	assign rem = last_pos - pos;
	assign is_zero = (pos < POS_WIDTH'(cfg.pad)) || (pos > last_real);

	assign go = active && !waiting && !almost_full;
	assign read_req = go && !is_zero && rd_ready;
	assign read_addr = addr_t'(pos - POS_WIDTH'(cfg.pad));

	// Padding enters at once, a real sample enters with its rd_valid
	assign enter = (go && is_zero) || (waiting && rd_valid);
	assign sample = waiting ? rd_data : '0;

	assign win_end = !tail && (skip == 2'd0);
	assign final_pos = (rem == '0);
	assign last_win = win_end && (rem < POS_WIDTH'(cfg.stride));

	assign shifted = taps >> OP_WIDTH;

	always_comb
	begin
		for (int i = 0; i < MAX_KW; i++)
		begin
			if (i < int'(cfg.kw))
				next_taps[i] = shifted[i];
			else if (i == int'(cfg.kw))
				next_taps[i] = sample; // Newest sample sits at tap kw
			else
				next_taps[i] = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active <= 1'b0;
			waiting <= 1'b0;
			tail <= 1'b0;
			skip <= 2'd0;
			pos <= '0;
			push <= 1'b0;
		end
		else if (layer_start)
		begin
			active <= 1'b1;
			waiting <= 1'b0;
			tail <= 1'b0;
			skip <= cfg.kw; // First window ends at position kw
			pos <= '0;
			push <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			if (read_req)
				waiting <= 1'b1;
			else if (rd_valid)
				waiting <= 1'b0;
			if (enter)
			begin
				pos <= pos + 1'b1;
				// The final window waits until every sample has been read
				push <= (win_end && !last_win) || final_pos;
				if (!tail)
					skip <= win_end ? 2'(cfg.stride - 3'd1) : skip - 2'd1;
				if (last_win)
					tail <= 1'b1;
				if (final_pos)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (enter)
		begin
			if (!tail)
				taps <= next_taps;
			push_last <= final_pos;
		end
	end

	assign push_data.taps = taps;
	assign push_data.last = push_last;

endmodule

// ==== pu_controller.sv ====
`timescale 1ns/1ps

module pu_controller import pu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic       layer_done,
	output layer_cfg_t cfg,
	output logic [1:0] layer_id,
	output logic       layer_start,
	output logic       done
);

	layer_cfg_t cfg_rom [NUM_LAYERS];
	ctrl_state_t state;
	logic last_layer;

	initial
	begin
		$readmemh("pu_cfg.mem", cfg_rom);
	end

	assign last_layer = (layer_id == 2'(NUM_LAYERS - 1));

	assign cfg = cfg_rom[layer_id]; // Stable while layer_id is held
	assign layer_start = (state == st_layer);
	assign done = (state == st_done);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			layer_id <= 2'd0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (start)
					begin
						layer_id <= 2'd0;
						state <= st_layer;
					end
				end
				st_layer:
					state <= st_wait; // One layer_start per layer
				st_wait:
				begin
					if (layer_done)
					begin
						if (last_layer)
							state <= st_done;
						else
						begin
							layer_id <= layer_id + 2'd1;
							state <= st_layer;
						end
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

// ==== pu_pkg.sv ====
package pu_pkg;

	localparam int NUM_PE = 4;
	localparam int NUM_LAYERS = 3;
	localparam int MAX_KW = 4;
	localparam int OP_WIDTH = 16;
	localparam int WEIGHT_WIDTH = 8;
	localparam int ACC_WIDTH = 32;
	localparam int FIFO_DEPTH = 8;
	localparam int ADDR_WIDTH = 10;

	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_WIDTH = FIFO_PTR_WIDTH + 1;
	localparam int POS_WIDTH = ADDR_WIDTH + 1; // Padded width reaches 1024 + 14

	typedef logic [OP_WIDTH-1:0] op_t;
	typedef logic [MAX_KW*WEIGHT_WIDTH-1:0] weight_vec_t; // Tap 0 in the low byte
	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	typedef struct packed {
		logic [1:0] kw; // Kernel width minus one
		logic [9:0] iw; // Input width minus one
		logic [2:0] pad;
		logic [2:0] stride;
	} layer_cfg_t;

	typedef struct packed {
		op_t [MAX_KW-1:0] taps; // Index 0 holds the oldest sample
		logic last;
	} window_t;

	typedef struct packed {
		acc_t [NUM_PE-1:0] sums;
		logic last;
	} result_t;

	typedef enum logic [1:0] {
		st_idle,
		st_layer,
		st_wait,
		st_done
	} ctrl_state_t;

endpackage
